/* src/icache_pkg.sv */
package icache_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // Byte offset bits within one instruction word
    localparam int offset_width = 2;

    // ------------------------------
    // Address map
    // ------------------------------
    // Top address byte of the uncached peripheral region
    localparam logic [7:0] bypass_region = 8'h0f;

    // ------------------------------
    // Read response codes
    // ------------------------------
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // ------------------------------
    // Controller state
    // ------------------------------
    // lookup  cached request, tag compare in progress or hit beat held
    // refill  miss, line fetched from memory
    // bypass  uncached request forwarded to memory
    typedef enum logic [1:0] {
        idle   = 2'b00,
        lookup = 2'b01,
        refill = 2'b10,
        bypass = 2'b11
    } refill_state_t;

endpackage

/* src/fetch_addr_decode.sv */
`timescale 1ns/1ns

module fetch_addr_decode #(
    parameter int INDEX_WIDTH = 3
) (
    input  logic [icache_pkg::addr_width-1:0] req_addr,
    output logic [icache_pkg::addr_width-icache_pkg::offset_width-INDEX_WIDTH-1:0] req_tag,
    output logic [INDEX_WIDTH-1:0]            req_index,
    output logic                              req_is_bypass
);
    import icache_pkg::*;

    localparam int tag_width = addr_width - offset_width - INDEX_WIDTH;

    // ------------------------------
    // Field split
    // ------------------------------
    // Address layout, from the top down:
    //   tag | index | byte offset
    // The byte offset is dropped since fetches are whole words

    // Tag is everything above the index
    assign req_tag = req_addr[addr_width-1 -: tag_width];

    // Index selects one line
    assign req_index = req_addr[offset_width +: INDEX_WIDTH];

    // ------------------------------
    // Region classification
    // ------------------------------
    // Peripheral space is never cached, so any change to the
    // uncached map belongs here and nowhere else
    always_comb begin
        if (req_addr[addr_width-1 -: 8] == bypass_region) begin
            req_is_bypass = 1'b1;
        end else begin
            req_is_bypass = 1'b0;
        end
    end

endmodule

/* src/icache_line_store.sv */
`timescale 1ns/1ns

module icache_line_store #(
    parameter int INDEX_WIDTH = 3
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [INDEX_WIDTH-1:0]            req_index,
    input  logic [icache_pkg::addr_width-icache_pkg::offset_width-INDEX_WIDTH-1:0] req_tag,
    input  logic                              fill_en,
    input  logic [icache_pkg::data_width-1:0] fill_data,
    output logic                              line_hit,
    output logic [icache_pkg::data_width-1:0] line_data
);
    import icache_pkg::*;

    localparam int tag_width = addr_width - offset_width - INDEX_WIDTH;
    localparam int line_count = 2 ** INDEX_WIDTH;

    // One entry per line
    logic [line_count-1:0] valid_q;
    logic [tag_width-1:0]  tag_mem  [line_count];
    logic [data_width-1:0] data_mem [line_count];

    // ------------------------------
    // Valid bits
    // ------------------------------
    // Only the valid bits need clearing to empty the cache
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[req_index] <= 1'b1;
        end
    end

    // ------------------------------
    // Tag and data arrays
    // ------------------------------
    always_ff @(posedge clock) begin
        if (fill_en) begin
            tag_mem[req_index]  <= req_tag;
            data_mem[req_index] <= fill_data;
        end
    end

    // Lookup compare
    assign line_hit  = valid_q[req_index] && (tag_mem[req_index] == req_tag);
    assign line_data = data_mem[req_index];

endmodule

/* src/icache_refill_ctrl.sv */
`timescale 1ns/1ns

module icache_refill_ctrl (
    input  logic                              clock,
    input  logic                              reset,
    // Fetch side request and response handshakes
    input  logic                              fetch_arvalid,
    output logic                              fetch_arready,
    input  logic [icache_pkg::addr_width-1:0] fetch_araddr,
    input  logic                              fetch_rready,
    output logic                              fetch_rvalid,
    // Decoder and line store
    output logic [icache_pkg::addr_width-1:0] req_addr,
    input  logic                              req_is_bypass,
    input  logic                              line_hit,
    // Memory side
    output logic                              mem_arvalid,
    input  logic                              mem_arready,
    output logic [icache_pkg::addr_width-1:0] mem_araddr,
    input  logic                              mem_rvalid,
    output logic                              mem_rready,
    input  logic [1:0]                        mem_rresp,
    // Fill strobe and state for the response path
    output logic                              fill_en,
    output icache_pkg::refill_state_t         sel_state
);
    import icache_pkg::*;

    refill_state_t         state;
    refill_state_t         state_next;
    logic [addr_width-1:0] addr_q;
    logic                  arvalid_q;
    logic                  accept;
    logic                  mem_phase;
    logic                  fetch_done;

    // ------------------------------
    // Handshake decode
    // ------------------------------
    assign fetch_arready = (state == idle);
    assign accept        = fetch_arvalid && fetch_arready;

    // Incoming address while idle, held request afterwards.
    // Lets the decoder classify the request in its accept cycle
    assign req_addr = (state == idle) ? fetch_araddr : addr_q;

    assign mem_arvalid = arvalid_q;
    assign mem_araddr  = addr_q;

    // Read beat window opens once the address has gone out
    assign mem_phase  = ((state == refill) || (state == bypass)) && !arvalid_q;
    assign mem_rready = mem_phase && fetch_rready;

    // Hit beat comes from the line store, all others from memory
    assign fetch_rvalid = ((state == lookup) && line_hit) || (mem_phase && mem_rvalid);
    assign fetch_done   = fetch_rvalid && fetch_rready;

    // Error beats are forwarded but never cached
    assign fill_en = (state == refill) && fetch_done && (mem_rresp == resp_okay);

    assign sel_state = state;

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (accept) begin
                    state_next = req_is_bypass ? bypass : lookup;
                end
            end
            lookup: begin
                if (!line_hit) begin
                    state_next = refill;
                end else if (fetch_done) begin
                    state_next = idle;
                end
            end
            refill, bypass: begin
                if (fetch_done) begin
                    state_next = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    // ------------------------------
    // State and memory request
    // ------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= idle;
            arvalid_q <= 1'b0;
        end else begin
            state <= state_next;
            if (accept && req_is_bypass) begin
                arvalid_q <= 1'b1;
            end else if ((state == lookup) && !line_hit) begin
                arvalid_q <= 1'b1;
            end else if (arvalid_q && mem_arready) begin
                arvalid_q <= 1'b0;
            end
        end
    end

    // Request address, held for the whole fetch
    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q <= fetch_araddr;
        end
    end

endmodule

/* src/fetch_response_select.sv */
`timescale 1ns/1ns

module fetch_response_select #(
    parameter int COUNT_WIDTH = 32
) (
    input  logic                              clock,
    input  logic                              reset,
    input  icache_pkg::refill_state_t         sel_state,
    input  logic [icache_pkg::data_width-1:0] line_data,
    input  logic [icache_pkg::data_width-1:0] mem_rdata,
    input  logic [1:0]                        mem_rresp,
    output logic [icache_pkg::data_width-1:0] fetch_rdata,
    output logic [1:0]                        fetch_rresp,
    input  logic                              fetch_rvalid,
    input  logic                              fetch_rready,
    output logic [COUNT_WIDTH-1:0]            hit_count,
    output logic [COUNT_WIDTH-1:0]            miss_count,
    output logic [COUNT_WIDTH-1:0]            bypass_count
);
    import icache_pkg::*;

    logic fetch_done;

    // ------------------------------
    // Response mux
    // ------------------------------
    // Hits always answer okay, memory beats carry their own code
    always_comb begin
        if (sel_state == lookup) begin
            fetch_rdata = line_data;
            fetch_rresp = resp_okay;
        end else begin
            fetch_rdata = mem_rdata;
            fetch_rresp = mem_rresp;
        end
    end

    // ------------------------------
    // Counters
    // ------------------------------
    assign fetch_done = fetch_rvalid && fetch_rready;

    // Each fetch counts once, on its final beat
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hit_count    <= '0;
            miss_count   <= '0;
            bypass_count <= '0;
        end else if (fetch_done) begin
            case (sel_state)
                lookup:  hit_count    <= hit_count + 1'b1;
                refill:  miss_count   <= miss_count + 1'b1;
                bypass:  bypass_count <= bypass_count + 1'b1;
                default: begin
                end
            endcase
        end
    end

endmodule

/* src/icache_top.sv */
`timescale 1ns/1ns

module icache_top #(
    parameter int INDEX_WIDTH = 3,
    parameter int COUNT_WIDTH = 32
) (
    input  logic                              clock,
    input  logic                              reset,
    // Fetch side, slave
    input  logic                              fetch_arvalid,
    output logic                              fetch_arready,
    input  logic [icache_pkg::addr_width-1:0] fetch_araddr,
    output logic                              fetch_rvalid,
    input  logic                              fetch_rready,
    output logic [icache_pkg::data_width-1:0] fetch_rdata,
    output logic [1:0]                        fetch_rresp,
    // Memory side, master
    output logic                              mem_arvalid,
    input  logic                              mem_arready,
    output logic [icache_pkg::addr_width-1:0] mem_araddr,
    input  logic                              mem_rvalid,
    output logic                              mem_rready,
    input  logic [icache_pkg::data_width-1:0] mem_rdata,
    input  logic [1:0]                        mem_rresp,
    // Counters
    output logic [COUNT_WIDTH-1:0]            hit_count,
    output logic [COUNT_WIDTH-1:0]            miss_count,
    output logic [COUNT_WIDTH-1:0]            bypass_count
);
    import icache_pkg::*;

    localparam int tag_width = addr_width - offset_width - INDEX_WIDTH;

    logic [addr_width-1:0]  req_addr;
    logic [tag_width-1:0]   req_tag;
    logic [INDEX_WIDTH-1:0] req_index;
    logic                   req_is_bypass;
    logic                   line_hit;
    logic [data_width-1:0]  line_data;
    logic                   fill_en;
    refill_state_t          sel_state;

    fetch_addr_decode #(.INDEX_WIDTH(INDEX_WIDTH)) decode_i (
        .req_addr(req_addr), .req_tag(req_tag),
        .req_index(req_index), .req_is_bypass(req_is_bypass)
    );

    icache_refill_ctrl ctrl_i (
        .clock(clock), .reset(reset),
        .fetch_arvalid(fetch_arvalid), .fetch_arready(fetch_arready),
        .fetch_araddr(fetch_araddr), .fetch_rready(fetch_rready),
        .fetch_rvalid(fetch_rvalid), .req_addr(req_addr),
        .req_is_bypass(req_is_bypass), .line_hit(line_hit),
        .mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
        .mem_araddr(mem_araddr), .mem_rvalid(mem_rvalid),
        .mem_rready(mem_rready), .mem_rresp(mem_rresp),
        .fill_en(fill_en), .sel_state(sel_state)
    );

    // Refill data comes straight off the memory read channel
    icache_line_store #(.INDEX_WIDTH(INDEX_WIDTH)) store_i (
        .clock(clock), .reset(reset), .req_index(req_index), .req_tag(req_tag),
        .fill_en(fill_en), .fill_data(mem_rdata),
        .line_hit(line_hit), .line_data(line_data)
    );

    fetch_response_select #(.COUNT_WIDTH(COUNT_WIDTH)) resp_i (
        .clock(clock), .reset(reset), .sel_state(sel_state),
        .line_data(line_data), .mem_rdata(mem_rdata), .mem_rresp(mem_rresp),
        .fetch_rdata(fetch_rdata), .fetch_rresp(fetch_rresp),
        .fetch_rvalid(fetch_rvalid), .fetch_rready(fetch_rready),
        .hit_count(hit_count), .miss_count(miss_count), .bypass_count(bypass_count)
    );

endmodule

/* bench/icache_chk.sv */
`timescale 1ns/1ns

module icache_chk (
    input logic                              clock,
    input logic                              reset,
    input logic                              fetch_arready,
    input logic                              fetch_rvalid,
    input logic                              fetch_rready,
    input logic [icache_pkg::data_width-1:0] fetch_rdata,
    input logic [1:0]                        fetch_rresp,
    input logic                              mem_arvalid,
    input logic                              mem_arready,
    input logic [icache_pkg::addr_width-1:0] mem_araddr
);

    // ------------------------------
    // Memory request channel
    // ------------------------------
    mem_ar_held: assert property (@(posedge clock) disable iff (reset)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
        else $error("mem_arvalid dropped or mem_araddr moved before mem_arready");

    // Fetch beat waits for the fetch unit
    fetch_r_held: assert property (@(posedge clock) disable iff (reset)
        fetch_rvalid && !fetch_rready |=>
            fetch_rvalid && $stable(fetch_rdata) && $stable(fetch_rresp))
        else $error("fetch_rvalid dropped or response moved before fetch_rready");

    // One request in flight
    one_in_flight: assert property (@(posedge clock) disable iff (reset)
        !(fetch_arready && fetch_rvalid))
        else $error("fetch_arready high while a response is pending");

endmodule

/* bench/icache_tb.sv */
`timescale 1ns/1ns

module icache_tb;
    import icache_pkg::*;

    localparam int INDEX_WIDTH = 3;
    localparam int COUNT_WIDTH = 32;
    localparam int max_cases   = 64;
    localparam int case_cycles = 64;
    localparam logic [31:0] mem_key = 32'h5eed_c0de;

    logic                   clock;
    logic                   reset;
    logic                   fetch_arvalid;
    logic                   fetch_arready;
    logic [addr_width-1:0]  fetch_araddr;
    logic                   fetch_rvalid;
    logic                   fetch_rready;
    logic [data_width-1:0]  fetch_rdata;
    logic [1:0]             fetch_rresp;
    logic                   mem_arvalid;
    logic                   mem_arready;
    logic [addr_width-1:0]  mem_araddr;
    logic                   mem_rvalid;
    logic                   mem_rready;
    logic [data_width-1:0]  mem_rdata;
    logic [1:0]             mem_rresp;
    logic [COUNT_WIDTH-1:0] hit_count;
    logic [COUNT_WIDTH-1:0] miss_count;
    logic [COUNT_WIDTH-1:0] bypass_count;

    // Four words per case: kind, address, hold cycles, source
    logic [31:0] case_words [0:4*max_cases-1];

    integer      seed = 32'haa83c9b8;
    int          mem_ar_count = 0;
    int          arvalid_cycles = 0;
    logic [31:0] mem_last_addr = '0;
    int          errors = 0;
    int          cases_passed = 0;
    int          cases_failed = 0;
    int          num_cases = 0;
    int          exp_hits = 0;
    int          exp_misses = 0;
    int          exp_bypasses = 0;
    int          cycle_count = 0;
    int          cycle_limit = case_cycles * max_cases;
    bit          verdict_printed = 0;

    icache_top #(.INDEX_WIDTH(INDEX_WIDTH), .COUNT_WIDTH(COUNT_WIDTH)) dut_i (
        .clock(clock), .reset(reset),
        .fetch_arvalid(fetch_arvalid), .fetch_arready(fetch_arready),
        .fetch_araddr(fetch_araddr), .fetch_rvalid(fetch_rvalid),
        .fetch_rready(fetch_rready), .fetch_rdata(fetch_rdata), .fetch_rresp(fetch_rresp),
        .mem_arvalid(mem_arvalid), .mem_arready(mem_arready), .mem_araddr(mem_araddr),
        .mem_rvalid(mem_rvalid), .mem_rready(mem_rready),
        .mem_rdata(mem_rdata), .mem_rresp(mem_rresp),
        .hit_count(hit_count), .miss_count(miss_count), .bypass_count(bypass_count)
    );

    bind icache_top icache_chk chk_i (
        .clock(clock), .reset(reset),
        .fetch_arready(fetch_arready), .fetch_rvalid(fetch_rvalid),
        .fetch_rready(fetch_rready), .fetch_rdata(fetch_rdata), .fetch_rresp(fetch_rresp),
        .mem_arvalid(mem_arvalid), .mem_arready(mem_arready), .mem_araddr(mem_araddr)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ------------------------------
    // Memory model
    // ------------------------------
    // Word is the address scrambled by a fixed key, 0xe0 region answers slverr
    initial begin : memory_model
        int delay;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        mem_rresp   = resp_okay;
        forever begin
            @(negedge clock);
            if (mem_arvalid) begin
                delay = {$random(seed)} % 6;
                repeat (delay) @(posedge clock);
                @(posedge clock);
                #1;
                mem_arready = 1'b1;
                @(negedge clock);
                mem_last_addr = mem_araddr;
                mem_ar_count++;
                @(posedge clock);
                #1;
                mem_arready = 1'b0;
                delay = {$random(seed)} % 6;
                repeat (delay) begin
                    @(posedge clock);
                    #1;
                end
                mem_rvalid = 1'b1;
                mem_rdata  = mem_last_addr ^ mem_key;
                mem_rresp  = (mem_last_addr[31:24] == 8'he0) ? resp_slverr : resp_okay;
                do @(negedge clock); while (!mem_rready);
                @(posedge clock);
                #1;
                mem_rvalid = 1'b0;
            end
        end
    end

    always @(negedge clock) begin
        if (mem_arvalid) begin
            arvalid_cycles++;
        end
    end

    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        verdict_printed = 1;
        $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
        $display(">>> FAIL");
        $finish;
    end

    // Run stopped early, for example by a failing bound assertion
    final begin
        if (!verdict_printed) begin
            $display(">>> FAIL");
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic string source_name(input logic [31:0] src);
        case (src)
            1: return "hit";
            2: return "miss";
            default: return "bypass";
        endcase
    endfunction

    task automatic expect_equal(input string where, input string name,
                                input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s %s got %h expected %h", where, name, got, exp);
            errors++;
        end
    endtask

    task automatic run_case(input int idx);
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] hold;
        logic [31:0] src;
        logic [31:0] first_data;
        logic [1:0]  first_resp;
        logic [31:0] hit_before;
        logic [31:0] miss_before;
        logic [31:0] bypass_before;
        int          mem_before;
        int          arvalid_before;
        int          errors_before;
        int          held;
        bit          seen;
        bit          done;
        string       where;

        kind = case_words[4*idx];
        addr = case_words[4*idx+1];
        hold = (kind == 1) ? case_words[4*idx+2] : 32'd0;
        src  = case_words[4*idx+3];
        where = $sformatf("case %0d", idx);
        first_data = '0;
        first_resp = '0;
        errors_before = errors;
        hit_before = hit_count;
        miss_before = miss_count;
        bypass_before = bypass_count;
        mem_before = mem_ar_count;
        arvalid_before = arvalid_cycles;

        // Address phase
        @(posedge clock);
        #1;
        fetch_arvalid = 1'b1;
        fetch_araddr  = addr;
        fetch_rready  = (hold == 0);
        do @(negedge clock); while (!fetch_arready);
        @(posedge clock);
        #1;
        fetch_arvalid = 1'b0;

        // Response phase, rready held low for the first hold beats
        seen = 0;
        done = 0;
        held = 0;
        while (!done) begin
            @(negedge clock);
            if (seen) begin
                assert (fetch_rvalid) else begin
                    $display("%s fetch_rvalid dropped before the transfer", where);
                    errors++;
                end
                expect_equal(where, "fetch_rdata", fetch_rdata, first_data);
                expect_equal(where, "fetch_rresp", {30'd0, fetch_rresp}, {30'd0, first_resp});
            end else if (fetch_rvalid) begin
                seen = 1;
                first_data = fetch_rdata;
                first_resp = fetch_rresp;
            end
            if (fetch_rvalid && fetch_rready) begin
                done = 1;
            end else begin
                if (fetch_rvalid) begin
                    held++;
                end
                @(posedge clock);
                #1;
                if (held >= hold) begin
                    fetch_rready = 1'b1;
                end
            end
        end
        expect_equal(where, "fetch_rdata", first_data, addr ^ mem_key);
        expect_equal(where, "fetch_rresp", {30'd0, first_resp},
                     (addr[31:24] == 8'he0) ? {30'd0, resp_slverr} : {30'd0, resp_okay});
        @(posedge clock);
        #1;
        fetch_rready = 1'b0;
        @(negedge clock);

        // Counters move on the transfer edge
        if (src == 1) begin
            exp_hits++;
            expect_equal(where, "mem_arvalid cycles", arvalid_cycles - arvalid_before, 0);
        end else begin
            if (src == 2) begin
                exp_misses++;
            end else begin
                exp_bypasses++;
            end
            expect_equal(where, "mem_ar transfers", mem_ar_count - mem_before, 1);
            expect_equal(where, "mem_araddr", mem_last_addr, addr);
        end
        expect_equal(where, "hit_count", hit_count, hit_before + ((src == 1) ? 32'd1 : 32'd0));
        expect_equal(where, "miss_count", miss_count,
                     miss_before + ((src == 2) ? 32'd1 : 32'd0));
        expect_equal(where, "bypass_count", bypass_count,
                     bypass_before + ((src == 3) ? 32'd1 : 32'd0));

        if (errors == errors_before) begin
            cases_passed++;
            $display("case %0d %s addr %h hold %0d ok", idx, source_name(src), addr, hold);
        end else begin
            cases_failed++;
            $display("case %0d %s addr %h hold %0d failed", idx, source_name(src), addr, hold);
        end
    endtask

    // ------------------------------
    // Case player
    // ------------------------------
    initial begin : player
        reset         = 1'b1;
        fetch_arvalid = 1'b0;
        fetch_araddr  = '0;
        fetch_rready  = 1'b0;
        $readmemh("bench/icache_cases.txt", case_words);
        while (num_cases < max_cases && case_words[4*num_cases] != 32'hff) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            $display("No cases were read from the case file");
            errors++;
        end
        cycle_limit = case_cycles * num_cases + 32;

        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        expect_equal("after reset", "fetch_arready", {31'd0, fetch_arready}, 1);
        expect_equal("after reset", "fetch_rvalid", {31'd0, fetch_rvalid}, 0);
        expect_equal("after reset", "mem_arvalid", {31'd0, mem_arvalid}, 0);
        expect_equal("after reset", "hit_count", hit_count, 0);
        expect_equal("after reset", "miss_count", miss_count, 0);
        expect_equal("after reset", "bypass_count", bypass_count, 0);

        for (int i = 0; i < num_cases; i++) begin
            if (case_words[4*i] > 1 || case_words[4*i+3] < 1 || case_words[4*i+3] > 3) begin
                $display("Case %0d has an unknown kind or source", i);
                errors++;
                cases_failed++;
            end else begin
                run_case(i);
            end
        end

        @(negedge clock);
        expect_equal("at end", "hit_count", hit_count, exp_hits);
        expect_equal("at end", "miss_count", miss_count, exp_misses);
        expect_equal("at end", "bypass_count", bypass_count, exp_bypasses);
        $display("%0d cases, %0d passed, %0d failed, %0d errors", num_cases, cases_passed,
                 cases_failed, errors);
        verdict_printed = 1;
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* bench/icache_cases.txt */
// kind address hold source, hex, one case per line
// kind 0 fetch, 1 fetch with rready held, source 1 hit 2 miss 3 bypass, kind ff ends
00 00001000 00 2
00 00001000 00 1
00 00001004 00 2
00 00002004 00 2
00 00001004 00 2
00 00001004 00 1
00 0f000010 00 3
00 0f000010 00 3
00 0f000010 00 3
01 00001000 03 1
01 00003008 04 2
01 0f000020 02 3
00 e0000010 00 2
00 e0000010 00 2
00 00001010 00 2
01 00001010 05 1
00 00003008 00 1
00 00001000 00 1
01 e0000018 02 2
00 0f000000 00 3
00 00002004 00 2
ff 00000000 00 0

/* project.f */
src/icache_pkg.sv
src/fetch_addr_decode.sv
src/icache_line_store.sv
src/icache_refill_ctrl.sv
src/fetch_response_select.sv
src/icache_top.sv
bench/icache_chk.sv
bench/icache_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = icache_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q '^>>> PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
